// File: verilog/cpu_types_pkg.sv
package cpu_types_pkg;

    // data path
    typedef logic [31:0] word_t;

    // register file index
    typedef logic [4:0] reg_addr_t;

    // raw immediate field of I-type instructions
    typedef logic [15:0] imm16_t;

    // word-addressed program counter, 512 instructions
    typedef logic [8:0] pc_t;

    // instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

endpackage

// File: verilog/ctrl_pkg.sv
package ctrl_pkg;

    import cpu_types_pkg::*;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_nor    = 4'd5,
        alu_slt    = 4'd6,
        alu_sltu   = 4'd7,
        alu_pass_b = 4'd8
    } alu_op_t;

    // operand b sources
    typedef enum logic [2:0] {
        src_reg   = 3'd0,
        src_sext  = 3'd1,
        src_zext  = 3'd2,
        src_upper = 3'd3,
        src_hi    = 3'd4,
        src_lo    = 3'd5,
        src_pc8   = 3'd6
    } src_sel_t;

    typedef logic [21:0] ctrl_word_t;

    // unlisted control word bits stay zero
    localparam int src_sel_msb   = 17;
    localparam int src_sel_lsb   = 15;
    localparam int alu_op_msb    = 14;
    localparam int alu_op_lsb    = 11;
    localparam int load_bit      = 10;
    localparam int rf_enable_bit = 9;
    localparam int branch_bit    = 8;
    localparam int dest_rt_bit   = 7;
    localparam int link_r31_bit  = 6;
    localparam int store_bit     = 5;

    // R-type function codes
    localparam funct_t fn_addu = 6'h21;
    localparam funct_t fn_subu = 6'h23;
    localparam funct_t fn_and  = 6'h24;
    localparam funct_t fn_or   = 6'h25;
    localparam funct_t fn_xor  = 6'h26;
    localparam funct_t fn_nor  = 6'h27;
    localparam funct_t fn_slt  = 6'h2a;
    localparam funct_t fn_sltu = 6'h2b;
    localparam funct_t fn_mfhi = 6'h10;
    localparam funct_t fn_mflo = 6'h12;

    // primary opcodes
    localparam opcode_t op_special = 6'h00;
    localparam opcode_t op_jal     = 6'h03;
    localparam opcode_t op_beq     = 6'h04;
    localparam opcode_t op_bne     = 6'h05;
    localparam opcode_t op_blez    = 6'h06;
    localparam opcode_t op_bgtz    = 6'h07;
    localparam opcode_t op_addiu   = 6'h09;
    localparam opcode_t op_slti    = 6'h0a;
    localparam opcode_t op_andi    = 6'h0c;
    localparam opcode_t op_ori     = 6'h0d;
    localparam opcode_t op_xori    = 6'h0e;
    localparam opcode_t op_lui     = 6'h0f;
    localparam opcode_t op_lw      = 6'h23;
    localparam opcode_t op_sw      = 6'h2b;

endpackage

// File: verilog/idex_if.sv
`timescale 1ns/10ps

interface idex_if import cpu_types_pkg::*, ctrl_pkg::*; ();

    ctrl_word_t ctrl;
    word_t      alu_a;
    word_t      pb;
    word_t      hi;
    word_t      lo;
    word_t      pc8;
    pc_t        pc;
    imm16_t     imm16;
    opcode_t    opcode;
    reg_addr_t  rd;
    reg_addr_t  rt;

    // pipeline register side
    modport stage (
        output ctrl, alu_a, pb, hi, lo, pc8, pc, imm16, opcode, rd, rt
    );

    // execute side
    modport ex (
        input ctrl, alu_a, pb, hi, lo, pc8, pc, imm16, opcode, rd, rt
    );

endinterface

// File: verilog/id_control_unit.sv
`timescale 1ns/10ps

module id_control_unit import cpu_types_pkg::*, ctrl_pkg::*; (
    input  opcode_t    opcode,
    input  funct_t     funct,
    output ctrl_word_t ctrl
);

    alu_op_t  alu_op;
    src_sel_t src_sel;
    logic     rf_enable;
    logic     load;
    logic     store;
    logic     branch;
    logic     dest_rt;
    logic     link_r31;

    always_comb begin
        alu_op    = alu_add;
        src_sel   = src_reg;
        rf_enable = 1'b0;
        load      = 1'b0;
        store     = 1'b0;
        branch    = 1'b0;
        dest_rt   = 1'b0;
        link_r31  = 1'b0;
        case (opcode)
            op_special: begin
                rf_enable = 1'b1;
                case (funct)
                    fn_addu: alu_op = alu_add;
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_nor:  alu_op = alu_nor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    fn_mfhi: begin
                        alu_op  = alu_pass_b;
                        src_sel = src_hi;
                    end
                    fn_mflo: begin
                        alu_op  = alu_pass_b;
                        src_sel = src_lo;
                    end
                    // unknown funct acts as a no-op
                    default: rf_enable = 1'b0;
                endcase
            end
            op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui, op_lw: begin
                rf_enable = 1'b1;
                dest_rt   = 1'b1;
                load      = (opcode == op_lw);
                case (opcode)
                    op_slti: begin
                        alu_op  = alu_slt;
                        src_sel = src_sext;
                    end
                    op_andi: begin
                        alu_op  = alu_and;
                        src_sel = src_zext;
                    end
                    op_ori: begin
                        alu_op  = alu_or;
                        src_sel = src_zext;
                    end
                    op_xori: begin
                        alu_op  = alu_xor;
                        src_sel = src_zext;
                    end
                    op_lui: begin
                        alu_op  = alu_pass_b;
                        src_sel = src_upper;
                    end
                    // addiu and lw add the sign-extended offset
                    default: src_sel = src_sext;
                endcase
            end
            op_sw: begin
                store   = 1'b1;
                src_sel = src_sext;
            end
            op_beq, op_bne, op_blez, op_bgtz: begin
                branch = 1'b1;
                alu_op = alu_sub;
            end
            op_jal: begin
                rf_enable = 1'b1;
                link_r31  = 1'b1;
                alu_op    = alu_pass_b;
                src_sel   = src_pc8;
            end
            default: ;
        endcase
    end

    always_comb begin
        ctrl                          = '0;
        ctrl[src_sel_msb:src_sel_lsb] = src_sel;
        ctrl[alu_op_msb:alu_op_lsb]   = alu_op;
        ctrl[load_bit]                = load;
        ctrl[rf_enable_bit]           = rf_enable;
        ctrl[branch_bit]              = branch;
        ctrl[dest_rt_bit]             = dest_rt;
        ctrl[link_r31_bit]            = link_r31;
        ctrl[store_bit]               = store;
    end

endmodule

// File: verilog/idex_stage.sv
`timescale 1ns/10ps

module idex_stage import cpu_types_pkg::*, ctrl_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  ctrl_word_t ctrl,
    input  word_t      mux_a,
    input  word_t      pb,
    input  word_t      hi,
    input  word_t      lo,
    input  word_t      pc8,
    input  pc_t        pc,
    input  imm16_t     imm16,
    input  opcode_t    opcode,
    input  reg_addr_t  rd,
    input  reg_addr_t  rt,
    idex_if.stage      idex
);

    // zero control word means no write, load, store or branch out of reset
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idex.ctrl   <= '0;
            idex.alu_a  <= '0;
            idex.pb     <= '0;
            idex.hi     <= '0;
            idex.lo     <= '0;
            idex.pc8    <= '0;
            idex.pc     <= '0;
            idex.imm16  <= '0;
            idex.opcode <= '0;
            idex.rd     <= '0;
            idex.rt     <= '0;
        end else begin
            idex.ctrl   <= ctrl;
            idex.alu_a  <= mux_a;
            idex.pb     <= pb;
            idex.hi     <= hi;
            idex.lo     <= lo;
            idex.pc8    <= pc8;
            idex.pc     <= pc;
            idex.imm16  <= imm16;
            idex.opcode <= opcode;
            idex.rd     <= rd;
            idex.rt     <= rt;
        end
    end

endmodule

// File: verilog/source_operand_handler.sv
`timescale 1ns/10ps

module source_operand_handler import ctrl_pkg::*; #(
    parameter int word_width = 32
) (
    idex_if.ex                     idex,
    output logic [word_width-1:0]  operand_b
);

    src_sel_t sel;

    assign sel = src_sel_t'(idex.ctrl[src_sel_msb:src_sel_lsb]);

    always_comb begin
        case (sel)
            src_sext:  operand_b = {{(word_width-16){idex.imm16[15]}}, idex.imm16};
            src_zext:  operand_b = {{(word_width-16){1'b0}}, idex.imm16};
            // lui puts the immediate in the upper half
            src_upper: operand_b = {idex.imm16, {(word_width-16){1'b0}}};
            src_hi:    operand_b = word_width'(idex.hi);
            src_lo:    operand_b = word_width'(idex.lo);
            src_pc8:   operand_b = word_width'(idex.pc8);
            default:   operand_b = word_width'(idex.pb);
        endcase
    end

endmodule

// File: verilog/alu.sv
`timescale 1ns/10ps

module alu import ctrl_pkg::*; #(
    parameter int word_width = 32
) (
    input  alu_op_t                op,
    input  logic [word_width-1:0]  a,
    input  logic [word_width-1:0]  b,
    output logic [word_width-1:0]  result,
    output logic                   zero
);

    logic lt_signed;
    logic lt_unsigned;

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add:    result = a + b;
            alu_sub:    result = a - b;
            alu_and:    result = a & b;
            alu_or:     result = a | b;
            alu_xor:    result = a ^ b;
            alu_nor:    result = ~(a | b);
            alu_slt:    result = {{(word_width-1){1'b0}}, lt_signed};
            alu_sltu:   result = {{(word_width-1){1'b0}}, lt_unsigned};
            alu_pass_b: result = b;
            default:    result = '0;
        endcase
    end

    // beq and bne look at this after alu_sub
    assign zero = (result == '0);

endmodule

// File: verilog/condition_handler.sv
`timescale 1ns/10ps

module condition_handler import cpu_types_pkg::*, ctrl_pkg::*; (
    idex_if.ex    idex,
    input  logic  alu_zero,
    output logic  branch_taken,
    output pc_t   branch_target
);

    // pc counts words and only the low 9 bits of the offset matter
    assign branch_target = idex.pc + pc_t'(1) + pc_t'(idex.imm16);

    always_comb begin
        branch_taken = 1'b0;
        if (idex.ctrl[branch_bit]) begin
            case (idex.opcode)
                op_beq:  branch_taken = alu_zero;
                op_bne:  branch_taken = !alu_zero;
                op_bgtz: branch_taken = $signed(idex.alu_a) > 0;
                op_blez: branch_taken = $signed(idex.alu_a) <= 0;
                default: branch_taken = 1'b0;
            endcase
        end
    end

endmodule

// File: verilog/ex_subsystem_top.sv
`timescale 1ns/10ps

module ex_subsystem_top import cpu_types_pkg::*, ctrl_pkg::*; #(
    parameter int word_width = 32
) (
    input  logic      clk,
    input  logic      reset,
    input  opcode_t   id_opcode,
    input  funct_t    id_funct,
    input  word_t     id_mux_a,
    input  word_t     id_pb,
    input  word_t     id_hi,
    input  word_t     id_lo,
    input  imm16_t    id_imm16,
    input  pc_t       id_pc,
    input  word_t     id_pc8,
    input  reg_addr_t id_rd,
    input  reg_addr_t id_rt,
    output word_t     ex_alu_result,
    output reg_addr_t ex_dest,
    output logic      ex_rf_enable,
    output logic      ex_load,
    output logic      ex_store,
    output logic      ex_branch_taken,
    output pc_t       ex_branch_target,
    output word_t     ex_store_data
);

    ctrl_word_t            id_ctrl;
    logic [word_width-1:0] operand_b;
    logic [word_width-1:0] alu_out;
    logic                  alu_zero;

    idex_if idex_bus ();

    id_control_unit i_control (
        .opcode (id_opcode),
        .funct  (id_funct),
        .ctrl   (id_ctrl)
    );

    idex_stage i_idex (
        .clk    (clk),
        .reset  (reset),
        .ctrl   (id_ctrl),
        .mux_a  (id_mux_a),
        .pb     (id_pb),
        .hi     (id_hi),
        .lo     (id_lo),
        .pc8    (id_pc8),
        .pc     (id_pc),
        .imm16  (id_imm16),
        .opcode (id_opcode),
        .rd     (id_rd),
        .rt     (id_rt),
        .idex   (idex_bus)
    );

    source_operand_handler #(.word_width(word_width)) i_src (
        .idex      (idex_bus),
        .operand_b (operand_b)
    );

    alu #(.word_width(word_width)) i_alu (
        .op     (alu_op_t'(idex_bus.ctrl[alu_op_msb:alu_op_lsb])),
        .a      (word_width'(idex_bus.alu_a)),
        .b      (operand_b),
        .result (alu_out),
        .zero   (alu_zero)
    );

    condition_handler i_cond (
        .idex          (idex_bus),
        .alu_zero      (alu_zero),
        .branch_taken  (ex_branch_taken),
        .branch_target (ex_branch_target)
    );

    // jal links to r31 and I-types write rt
    always_comb begin
        if (idex_bus.ctrl[link_r31_bit]) begin
            ex_dest = reg_addr_t'(31);
        end else if (idex_bus.ctrl[dest_rt_bit]) begin
            ex_dest = idex_bus.rt;
        end else begin
            ex_dest = idex_bus.rd;
        end
    end

    assign ex_alu_result = word_t'(alu_out);
    assign ex_rf_enable  = idex_bus.ctrl[rf_enable_bit];
    assign ex_load       = idex_bus.ctrl[load_bit];
    assign ex_store      = idex_bus.ctrl[store_bit];
    assign ex_store_data = idex_bus.pb;

endmodule

// File: bench/ex_tb.sv
`timescale 1ns/10ps

module ex_tb import cpu_types_pkg::*, ctrl_pkg::*; ();

    typedef struct packed {
        word_t     result;
        reg_addr_t dest;
        logic      rf_enable;
        logic      load;
        logic      store;
        logic      taken;
        pc_t       target;
        word_t     store_data;
    } expect_t;

    // reset and reset check, then each test's instructions plus one drain cycle
    localparam int test_cycles = 5 + 1 + 8 * 40 + 8 * 8 + 4 * 5 + 3 + 60 + 6;
    localparam int max_cycles  = 2 * test_cycles;
    localparam opcode_t op_none = 6'h3f;

    logic      clk;
    logic      reset;
    opcode_t   id_opcode;
    funct_t    id_funct;
    word_t     id_mux_a;
    word_t     id_pb;
    word_t     id_hi;
    word_t     id_lo;
    imm16_t    id_imm16;
    pc_t       id_pc;
    word_t     id_pc8;
    reg_addr_t id_rd;
    reg_addr_t id_rt;
    word_t     ex_alu_result;
    reg_addr_t ex_dest;
    logic      ex_rf_enable;
    logic      ex_load;
    logic      ex_store;
    logic      ex_branch_taken;
    pc_t       ex_branch_target;
    word_t     ex_store_data;

    int      cycles = 0;
    int      errors = 0;
    int      start_errors;
    int      tests_passed = 0;
    int      tests_failed = 0;
    int      seed;
    string   cur_test;
    string   pend_name;
    logic    pending = 1'b0;
    expect_t pend;

    funct_t  r_fns [10] = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor, fn_nor, fn_slt,
                            fn_sltu, fn_mfhi, fn_mflo};
    opcode_t i_ops [8]  = '{op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui,
                            op_lw, op_sw};
    opcode_t b_ops [4]  = '{op_beq, op_bne, op_blez, op_bgtz};
    opcode_t all_ops [13] = '{op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui,
                              op_lw, op_sw, op_beq, op_bne, op_blez, op_bgtz, op_jal};

    ex_subsystem_top #(.word_width(32)) i_dut (
        .clk              (clk),
        .reset            (reset),
        .id_opcode        (id_opcode),
        .id_funct         (id_funct),
        .id_mux_a         (id_mux_a),
        .id_pb            (id_pb),
        .id_hi            (id_hi),
        .id_lo            (id_lo),
        .id_imm16         (id_imm16),
        .id_pc            (id_pc),
        .id_pc8           (id_pc8),
        .id_rd            (id_rd),
        .id_rt            (id_rt),
        .ex_alu_result    (ex_alu_result),
        .ex_dest          (ex_dest),
        .ex_rf_enable     (ex_rf_enable),
        .ex_load          (ex_load),
        .ex_store         (ex_store),
        .ex_branch_taken  (ex_branch_taken),
        .ex_branch_target (ex_branch_target),
        .ex_store_data    (ex_store_data)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: run did not finish within %0d cycles", max_cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // reference model of one instruction through execute
    function automatic expect_t predict(opcode_t op, funct_t fn, word_t a, word_t b,
                                        word_t hi, word_t lo, imm16_t imm, pc_t pc,
                                        word_t pc8, reg_addr_t rd, reg_addr_t rt);
        expect_t e;
        word_t   sx;
        word_t   zx;
        sx = {{16{imm[15]}}, imm};
        zx = {16'h0000, imm};
        e = '0;
        e.result     = a + b;
        e.dest       = rd;
        e.store_data = b;
        e.target     = pc + 9'd1 + sx[8:0];
        case (op)
            op_special: begin
                e.rf_enable = 1'b1;
                case (fn)
                    fn_addu: e.result = a + b;
                    fn_subu: e.result = a - b;
                    fn_and:  e.result = a & b;
                    fn_or:   e.result = a | b;
                    fn_xor:  e.result = a ^ b;
                    fn_nor:  e.result = ~(a | b);
                    fn_slt:  e.result = (a[31] != b[31]) ? a[31] : (a < b);
                    fn_sltu: e.result = (a < b);
                    fn_mfhi: e.result = hi;
                    fn_mflo: e.result = lo;
                    default: e.rf_enable = 1'b0;
                endcase
            end
            op_addiu, op_lw: e.result = a + sx;
            op_sw:   e.result = a + sx;
            op_slti: e.result = (a[31] != sx[31]) ? a[31] : (a < sx);
            op_andi: e.result = a & zx;
            op_ori:  e.result = a | zx;
            op_xori: e.result = a ^ zx;
            op_lui:  e.result = {imm, 16'h0000};
            op_beq:  e.taken = (a == b);
            op_bne:  e.taken = (a != b);
            op_blez: e.taken = a[31] || (a == 0);
            op_bgtz: e.taken = !a[31] && (a != 0);
            op_jal: begin
                e.result    = pc8;
                e.dest      = 5'd31;
                e.rf_enable = 1'b1;
            end
            default: ;
        endcase
        if (op inside {op_beq, op_bne, op_blez, op_bgtz}) begin
            e.result = a - b;
        end
        if (op inside {op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui, op_lw}) begin
            e.rf_enable = 1'b1;
            e.dest      = rt;
        end
        e.load  = (op == op_lw);
        e.store = (op == op_sw);
        return e;
    endfunction

    task automatic compare_value(input string field, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("mismatch in %s (%s): expected %h, actual %h", pend_name, field, exp, act);
            errors++;
        end
    endtask

    task automatic check_outputs(input expect_t e);
        compare_value("alu_result", e.result, ex_alu_result);
        if (e.rf_enable) begin
            compare_value("dest", e.dest, ex_dest);
        end
        compare_value("rf_enable", e.rf_enable, ex_rf_enable);
        compare_value("load", e.load, ex_load);
        compare_value("store", e.store, ex_store);
        compare_value("branch_taken", e.taken, ex_branch_taken);
        compare_value("branch_target", e.target, ex_branch_target);
        compare_value("store_data", e.store_data, ex_store_data);
    endtask

    // drives one instruction and checks the one issued a cycle before
    task automatic issue_instr(input opcode_t op, input funct_t fn, input word_t a,
                               input word_t b, input imm16_t imm, input pc_t pc,
                               input reg_addr_t rd, input reg_addr_t rt);
        word_t hi_v;
        word_t lo_v;
        word_t pc8_v;
        hi_v  = $urandom;
        lo_v  = $urandom;
        pc8_v = $urandom;
        @(posedge clk);
        id_opcode <= op;
        id_funct  <= fn;
        id_mux_a  <= a;
        id_pb     <= b;
        id_hi     <= hi_v;
        id_lo     <= lo_v;
        id_imm16  <= imm;
        id_pc     <= pc;
        id_pc8    <= pc8_v;
        id_rd     <= rd;
        id_rt     <= rt;
        @(negedge clk);
        if (pending) begin
            check_outputs(pend);
        end
        pend      = predict(op, fn, a, b, hi_v, lo_v, imm, pc, pc8_v, rd, rt);
        pend_name = cur_test;
        pending   = 1'b1;
    endtask

    task automatic issue_random(input opcode_t op, input funct_t fn);
        issue_instr(op, fn, $urandom, $urandom, imm16_t'($urandom), pc_t'($urandom),
                    reg_addr_t'($urandom), reg_addr_t'($urandom));
    endtask

    task automatic drive_branch(input opcode_t op, input word_t a, input word_t b);
        issue_instr(op, '0, a, b, imm16_t'($urandom), pc_t'($urandom), 5'd1, 5'd2);
    endtask

    task automatic start_test(input string name);
        cur_test     = name;
        start_errors = errors;
    endtask

    task automatic end_test();
        int n;
        // an unknown opcode flushes out the last check
        issue_instr(op_none, '0, '0, '0, '0, '0, '0, '0);
        pending = 1'b0;
        n = errors - start_errors;
        if (n == 0) begin
            tests_passed++;
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, n);
        end
    endtask

    task automatic verify_reset_state();
        start_test("reset_state");
        @(negedge clk);
        pend_name = cur_test;
        compare_value("rf_enable", 0, ex_rf_enable);
        compare_value("load", 0, ex_load);
        compare_value("store", 0, ex_store);
        compare_value("branch_taken", 0, ex_branch_taken);
        end_test();
    endtask

    task automatic sweep_r_type_alu();
        start_test("r_type_alu");
        for (int f = 0; f < 8; f++) begin
            repeat (40) issue_random(op_special, r_fns[f]);
        end
        end_test();
    endtask

    task automatic sweep_i_type_operands();
        start_test("i_type_operands");
        foreach (i_ops[k]) begin
            repeat (8) issue_random(i_ops[k], funct_t'($urandom));
        end
        end_test();
    endtask

    task automatic exercise_branches();
        start_test("branches");
        foreach (b_ops[k]) begin
            drive_branch(b_ops[k], 32'd5, 32'd5);
            drive_branch(b_ops[k], 32'd3, 32'd9);
            drive_branch(b_ops[k], -32'sd4, $urandom);
            drive_branch(b_ops[k], 32'd0, $urandom);
            drive_branch(b_ops[k], 32'd7, $urandom);
        end
        end_test();
    endtask

    task automatic exercise_link_and_hilo();
        start_test("link_and_hilo");
        issue_random(op_jal, '0);
        issue_random(op_special, fn_mfhi);
        issue_random(op_special, fn_mflo);
        end_test();
    endtask

    task automatic stream_back_to_back();
        int k;
        start_test("back_to_back");
        repeat (60) begin
            k = $urandom_range(0, 22);
            if (k < 10) begin
                issue_random(op_special, r_fns[k]);
            end else begin
                issue_random(all_ops[k - 10], funct_t'($urandom));
            end
        end
        end_test();
    endtask

    initial begin
        seed = 32'h8c10;
        void'($urandom(seed));
        clk       = 1'b0;
        reset     = 1'b1;
        id_opcode = '0;
        id_funct  = '0;
        id_mux_a  = '0;
        id_pb     = '0;
        id_hi     = '0;
        id_lo     = '0;
        id_imm16  = '0;
        id_pc     = '0;
        id_pc8    = '0;
        id_rd     = '0;
        id_rt     = '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        verify_reset_state();
        sweep_r_type_alu();
        sweep_i_type_operands();
        exercise_branches();
        exercise_link_and_hilo();
        stream_back_to_back();
        $display("tests passed: %0d, tests failed: %0d, mismatches: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: sim.f
verilog/cpu_types_pkg.sv
verilog/ctrl_pkg.sv
verilog/idex_if.sv
verilog/id_control_unit.sv
verilog/idex_stage.sv
verilog/source_operand_handler.sv
verilog/alu.sv
verilog/condition_handler.sv
verilog/ex_subsystem_top.sv
bench/ex_tb.sv
